// File: files.f
+incdir+include
verilog/cmd_pkg.sv
verilog/ram_2p_asym.sv
verilog/fifo_sync_asym.sv
verilog/cmd_decode.sv
verilog/cmd_execute.sv
verilog/result_stage.sv
verilog/byte_cmd_engine.sv
sim/byte_cmd_engine_chk.sv
sim/byte_cmd_engine_tb.sv

// File: include/fifo_util.svh
`ifndef FIFO_UTIL_SVH
`define FIFO_UTIL_SVH

// wider and narrower of two port widths
`define FIFO_MAX(a, b) (((a) > (b)) ? (a) : (b))
`define FIFO_MIN(a, b) (((a) < (b)) ? (a) : (b))

`endif

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module byte_cmd_engine_tb \
   -Mdir obj_dir -o byte_cmd_engine_sim

./obj_dir/byte_cmd_engine_sim

// File: sim/byte_cmd_engine_chk.sv
`timescale 1ns/100ps

module byte_cmd_engine_chk #(
   parameter R_DATA_W = 32,
   parameter ADDR_W   = 4
) (
   input logic                clk,
   input logic                reset,
   input logic                w_en,
   input logic                w_full,
   input logic                r_en,
   input logic                r_empty,
   input logic [R_DATA_W-1:0] r_data,
   input logic [ADDR_W:0]     level
);

   localparam int fifo_size = 2 ** ADDR_W;

   // level is counted in narrow units
   level_in_range: assert property (@(posedge clk) disable iff (reset)
      int'(level) <= fifo_size)
      else $error("FIFO level %0d is above the size %0d", level, fifo_size);

   full_write_ignored: assert property (@(posedge clk) disable iff (reset)
      w_full && w_en && !r_en |=> $stable(level))
      else $error("FIFO level moved on a write into a full FIFO");

   // registered read, data one cycle after the pop
   read_data_known: assert property (@(posedge clk) disable iff (reset)
      r_en && !r_empty |=> !$isunknown(r_data))
      else $error("FIFO read data is unknown after an accepted read");

endmodule

// File: sim/byte_cmd_engine_tb.sv
`timescale 1ns/100ps

module byte_cmd_engine_tb;

   import cmd_pkg::*;

   localparam int timeout_cycles = 500;

   logic        clk;
   logic        reset;
   logic        run;
   logic        cmd_we;
   logic [7:0]  cmd_data;
   logic        cmd_full;
   logic [4:0]  cmd_level;
   logic        res_re;
   logic [7:0]  res_data;
   logic        res_empty;
   logic [4:0]  res_level;
   logic        bad_cmd;
   logic [15:0] lfsr;
   logic [31:0] model_acc;
   logic [7:0]  exp_q [$];
   logic [7:0]  op;
   logic [31:0] word;
   int          i;
   int          j;
   int          n;

   byte_cmd_engine byte_cmd_engine_i (.*);

   bind fifo_sync_asym byte_cmd_engine_chk #(
      .R_DATA_W (R_DATA_W),
      .ADDR_W   (ADDR_W)
   ) chk_i (
      .clk     (clk),
      .reset   (reset),
      .w_en    (w_en),
      .w_full  (w_full),
      .r_en    (r_en),
      .r_empty (r_empty),
      .r_data  (r_data),
      .level   (level)
   );

   always #50 clk = ~clk;

   // 16 bit galois lfsr stepped once per bit taken
   function automatic logic [31:0] rand_bits(input int width);
      logic [31:0] v;
      int          k;
      v = '0;
      for (k = 0; k < width; k++) begin
         v    = {v[30:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
      end
      return v;
   endfunction

   // reference accumulator where unknown codes act as nop
   function automatic void model_cmd(input logic [31:0] cmd);
      int k;
      case (cmd[31:24])
         8'(op_load): model_acc = {8'h00, cmd[23:0]};
         8'(op_add):  model_acc = model_acc + {8'h00, cmd[23:0]};
         8'(op_xor):  model_acc[23:0] = model_acc[23:0] ^ cmd[23:0];
         8'(op_emit): begin
            // lsb goes out first
            for (k = 0; k < 4; k++) begin
               exp_q.push_back(model_acc[8*k +: 8]);
            end
         end
         default: ;
      endcase
   endfunction

   task automatic stop_failed(input string why);
      $display("%s", why);
      $display("Simulation FAILED");
      $fatal(1);
   endtask

   task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp) else begin
         stop_failed($sformatf("Fail %s: got %h, expected %h", name, got, exp));
      end
   endtask

   task automatic push_byte(input logic [7:0] b);
      int cnt;
      cnt = 0;
      while (cmd_full) begin
         @(negedge clk);
         cnt++;
         if (cnt > timeout_cycles) begin
            stop_failed("command FIFO stayed full, byte could not be written");
         end
      end
      cmd_we   = 1'b1;
      cmd_data = b;
      @(negedge clk);
      cmd_we = 1'b0;
   endtask

   task automatic push_cmd(input logic [7:0] code, input logic [23:0] operand);
      logic [31:0] cmd;
      int          k;
      cmd = {code, operand};
      model_cmd(cmd);
      for (k = 0; k < 4; k++) begin
         push_byte(cmd[8*k +: 8]);
      end
   endtask

   // pop result bytes until the model has nothing left
   task automatic drain_results();
      int cnt;
      while (exp_q.size() > 0) begin
         cnt = 0;
         while (res_empty) begin
            @(negedge clk);
            cnt++;
            if (cnt > timeout_cycles) begin
               stop_failed("no result byte became readable in time");
            end
         end
         res_re = 1'b1;
         @(negedge clk);
         res_re = 1'b0;
         check_eq("res_data", 32'(res_data), 32'(exp_q.pop_front()));
      end
   endtask

   initial begin
      clk       = 1'b0;
      reset     = 1'b1;
      run       = 1'b0;
      cmd_we    = 1'b0;
      cmd_data  = 8'h00;
      res_re    = 1'b0;
      lfsr      = 16'd48449;
      model_acc = '0;
      repeat (3) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      check_eq("res_empty", 32'(res_empty), 32'd1);
      check_eq("cmd_full", 32'(cmd_full), 32'd0);
      check_eq("cmd_level", 32'(cmd_level), 32'd0);
      check_eq("res_level", 32'(res_level), 32'd0);
      check_eq("bad_cmd", 32'(bad_cmd), 32'd0);

      // fill with run low using load, add, xor and emit
      for (i = 0; i < 4; i++) begin
         word = {8'(i + 1), 24'(rand_bits(24))};
         model_cmd(word);
         for (j = 0; j < 4; j++) begin
            push_byte(word[8*j +: 8]);
            check_eq("cmd_level", 32'(cmd_level), 32'(4 * i + j + 1));
            check_eq("cmd_full", 32'(cmd_full), 32'(4 * i + j == 15));
         end
      end
      // seventeenth byte is dropped
      cmd_we   = 1'b1;
      cmd_data = 8'hee;
      @(negedge clk);
      cmd_we = 1'b0;
      check_eq("cmd_level", 32'(cmd_level), 32'd16);

      // random stream drained after every emit
      run = 1'b1;
      for (i = 0; i < 40; i++) begin
         op = 8'(rand_bits(2) + 1);
         push_cmd(op, 24'(rand_bits(24)));
         if (op == 8'(op_emit)) begin
            drain_results();
         end
      end
      drain_results();

      // of six unread emits four words fit and the rest wait upstream
      for (i = 0; i < 6; i++) begin
         push_cmd(8'(op_add), 24'(rand_bits(24)));
         push_cmd(8'(op_emit), 24'h000000);
      end
      n = 0;
      while (res_level != 5'd16) begin
         @(negedge clk);
         n++;
         if (n > timeout_cycles) begin
            stop_failed("result FIFO never filled up under back-pressure");
         end
      end
      repeat (8) begin
         @(negedge clk);
         check_eq("res_level", 32'(res_level), 32'd16);
      end
      drain_results();

      // unknown opcode
      check_eq("bad_cmd", 32'(bad_cmd), 32'd0);
      push_cmd(8'h9a, 24'(rand_bits(24)));
      n = 0;
      while (!bad_cmd) begin
         @(negedge clk);
         n++;
         if (n > timeout_cycles) begin
            stop_failed("bad_cmd did not rise after an unknown opcode");
         end
      end
      push_cmd(8'(op_emit), 24'h000000);
      drain_results();
      check_eq("bad_cmd", 32'(bad_cmd), 32'd1);

      // read on an empty result FIFO
      check_eq("res_empty", 32'(res_empty), 32'd1);
      res_re = 1'b1;
      @(negedge clk);
      res_re = 1'b0;
      check_eq("res_level", 32'(res_level), 32'd0);
      check_eq("res_empty", 32'(res_empty), 32'd1);
      push_cmd(8'(op_load), 24'(rand_bits(24)));
      push_cmd(8'(op_xor), 24'(rand_bits(24)));
      push_cmd(8'(op_emit), 24'h000000);
      drain_results();
      check_eq("bad_cmd", 32'(bad_cmd), 32'd1);

      $display("Simulation PASSED");
      $finish;
   end

endmodule

// File: verilog/byte_cmd_engine.sv
`timescale 1ns/100ps

module byte_cmd_engine #(
   parameter CMD_ADDR_W = 4,
   parameter RES_ADDR_W = 4
) (
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       run,
   input  logic                       cmd_we,
   input  logic [cmd_pkg::byte_w-1:0] cmd_data,
   output logic                       cmd_full,
   output logic [CMD_ADDR_W:0]        cmd_level,
   input  logic                       res_re,
   output logic [cmd_pkg::byte_w-1:0] res_data,
   output logic                       res_empty,
   output logic [RES_ADDR_W:0]        res_level,
   output logic                       bad_cmd
);

   import cmd_pkg::*;

   logic              cmd_empty;
   logic              cmd_rd;
   cmd_word_t         cmd_word;
   dec_op_t           dec_op;
   logic              exec_stall;
   res_t              res;
   logic              res_busy;
   logic              res_wr;
   logic [word_w-1:0] res_wdata;
   logic              res_full;

   // host bytes in, command words out
   fifo_sync_asym #(
      .W_DATA_W (byte_w),
      .R_DATA_W (word_w),
      .ADDR_W   (CMD_ADDR_W)
   ) cmd_fifo (
      .clk     (clk),
      .reset   (reset),
      .w_en    (cmd_we),
      .w_data  (cmd_data),
      .w_full  (cmd_full),
      .r_en    (cmd_rd),
      .r_data  (cmd_word),
      .r_empty (cmd_empty),
      .level   (cmd_level)
   );

   cmd_decode cmd_decode_i (
      .clk        (clk),
      .reset      (reset),
      .run        (run),
      .fifo_empty (cmd_empty),
      .fifo_rd    (cmd_rd),
      .fifo_word  (cmd_word),
      .exec_stall (exec_stall),
      .dec_op     (dec_op),
      .bad_cmd    (bad_cmd)
   );

   cmd_execute cmd_execute_i (
      .clk        (clk),
      .reset      (reset),
      .dec_op     (dec_op),
      .exec_stall (exec_stall),
      .res_busy   (res_busy),
      .res        (res)
   );

   result_stage result_stage_i (
      .clk        (clk),
      .reset      (reset),
      .res        (res),
      .res_busy   (res_busy),
      .fifo_wr    (res_wr),
      .fifo_wdata (res_wdata),
      .fifo_full  (res_full)
   );

   // result words in, host bytes out
   fifo_sync_asym #(
      .W_DATA_W (word_w),
      .R_DATA_W (byte_w),
      .ADDR_W   (RES_ADDR_W)
   ) res_fifo (
      .clk     (clk),
      .reset   (reset),
      .w_en    (res_wr),
      .w_data  (res_wdata),
      .w_full  (res_full),
      .r_en    (res_re),
      .r_data  (res_data),
      .r_empty (res_empty),
      .level   (res_level)
   );

endmodule

// File: verilog/cmd_decode.sv
`timescale 1ns/100ps

module cmd_decode (
   input  logic               clk,
   input  logic               reset,
   input  logic               run,
   input  logic               fifo_empty,
   output logic               fifo_rd,
   input  cmd_pkg::cmd_word_t fifo_word,
   input  logic               exec_stall,
   output cmd_pkg::dec_op_t   dec_op,
   output logic               bad_cmd
);

   import cmd_pkg::*;

   logic    rd_pend;
   logic    consume;
   logic    load;
   cmd_op_e op_dec;
   logic    op_bad;

   // unknown codes become nop and get flagged
   always_comb begin
      if (fifo_word.opcode <= opcode_w'(op_emit)) begin
         op_dec = cmd_op_e'(fifo_word.opcode[2:0]);
         op_bad = 1'b0;
      end else begin
         op_dec = op_nop;
         op_bad = 1'b1;
      end
   end

   // rd_pend means the fifo output register holds a word not yet taken
   assign consume = dec_op.valid && !exec_stall;
   assign load    = rd_pend && (!dec_op.valid || consume);

   // two slots: fifo output register and dec_op
   // pop only if the pending word moves on this cycle
   assign fifo_rd = run && !fifo_empty && (!rd_pend || load);

   always_ff @(posedge clk) begin
      if (reset) begin
         rd_pend      <= 1'b0;
         dec_op.valid <= 1'b0;
         bad_cmd      <= 1'b0;
      end else begin
         rd_pend <= fifo_rd || (rd_pend && !load);
         if (load) begin
            dec_op.valid   <= 1'b1;
            dec_op.op      <= op_dec;
            dec_op.operand <= fifo_word.operand;
         end else if (consume) begin
            dec_op.valid <= 1'b0;
         end
         // sticky until reset
         if (load && op_bad) begin
            bad_cmd <= 1'b1;
         end
      end
   end

endmodule

// File: verilog/cmd_execute.sv
`timescale 1ns/100ps

module cmd_execute (
   input  logic             clk,
   input  logic             reset,
   input  cmd_pkg::dec_op_t dec_op,
   output logic             exec_stall,
   input  logic             res_busy,
   output cmd_pkg::res_t    res
);

   import cmd_pkg::*;

   logic [word_w-1:0] acc;
   logic [word_w-1:0] acc_nxt;
   logic              fire;
   logic              is_emit;

   assign is_emit = dec_op.op == op_emit;

   // only an emit can be held back, and only by a blocked result stage
   assign exec_stall = dec_op.valid && is_emit && res_busy;
   assign fire       = dec_op.valid && !exec_stall;

   always_comb begin
      case (dec_op.op)
         op_load: begin
            acc_nxt = word_w'(dec_op.operand);
         end
         op_add: begin
            // wraps modulo 2^32
            acc_nxt = acc + word_w'(dec_op.operand);
         end
         op_xor: begin
            // upper byte untouched
            acc_nxt = {acc[word_w-1:operand_w], acc[operand_w-1:0] ^ dec_op.operand};
         end
         default: begin
            acc_nxt = acc;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         acc <= '0;
      end else if (fire) begin
         acc <= acc_nxt;
      end
   end

   // emit shows the value from before this edge, valid for one cycle
   assign res.valid = fire && is_emit;
   assign res.data  = acc;

endmodule

// File: verilog/cmd_pkg.sv
package cmd_pkg;

   // host side and word side widths
   localparam int byte_w    = 8;
   localparam int word_w    = 32;
   localparam int operand_w = 24;
   localparam int opcode_w  = word_w - operand_w;

   typedef enum logic [2:0] {
      op_nop  = 3'd0,
      op_load = 3'd1,
      op_add  = 3'd2,
      op_xor  = 3'd3,
      op_emit = 3'd4
   } cmd_op_e;

   // raw command word as assembled from four host bytes
   typedef struct packed {
      logic [opcode_w-1:0]  opcode;
      logic [operand_w-1:0] operand;
   } cmd_word_t;

   typedef struct packed {
      logic                 valid;
      cmd_op_e              op;
      logic [operand_w-1:0] operand;
   } dec_op_t;

   typedef struct packed {
      logic              valid;
      logic [word_w-1:0] data;
   } res_t;

endpackage

// File: verilog/fifo_sync_asym.sv
`timescale 1ns/100ps
`include "fifo_util.svh"

module fifo_sync_asym #(
   parameter W_DATA_W  = 8,
   parameter R_DATA_W  = 32,
   parameter ADDR_W    = 4,
   parameter MAXDATA_W = `FIFO_MAX(W_DATA_W, R_DATA_W),
   parameter MINDATA_W = `FIFO_MIN(W_DATA_W, R_DATA_W),
   parameter N         = MAXDATA_W / MINDATA_W,
   parameter MINADDR_W = ADDR_W - $clog2(N),
   parameter W_ADDR_W  = (W_DATA_W == MAXDATA_W) ? MINADDR_W : ADDR_W,
   parameter R_ADDR_W  = (R_DATA_W == MAXDATA_W) ? MINADDR_W : ADDR_W
) (
   input  logic                clk,
   input  logic                reset,
   input  logic                w_en,
   input  logic [W_DATA_W-1:0] w_data,
   output logic                w_full,
   input  logic                r_en,
   output logic [R_DATA_W-1:0] r_data,
   output logic                r_empty,
   output logic [ADDR_W:0]     level
);

   // level is kept in narrow units, the wide side moves N at a time
   localparam int W_INCR_I = (W_DATA_W == MAXDATA_W) ? N : 1;
   localparam int R_INCR_I = (R_DATA_W == MAXDATA_W) ? N : 1;
   localparam int SIZE_I   = 2 ** ADDR_W;

   localparam logic [ADDR_W:0] W_INCR    = W_INCR_I[ADDR_W:0];
   localparam logic [ADDR_W:0] R_INCR    = R_INCR_I[ADDR_W:0];
   localparam logic [ADDR_W:0] FULL_MARK = SIZE_I[ADDR_W:0] - W_INCR;

   logic                w_en_int;
   logic                r_en_int;
   logic [W_ADDR_W-1:0] w_addr;
   logic [R_ADDR_W-1:0] r_addr;
   logic [ADDR_W:0]     level_nxt;

   // requests on a full or empty fifo are dropped here
   assign w_en_int = w_en & ~w_full;
   assign r_en_int = r_en & ~r_empty;

   always_comb begin
      level_nxt = level;
      if (w_en_int) begin
         level_nxt = level_nxt + W_INCR;
      end
      if (r_en_int) begin
         level_nxt = level_nxt - R_INCR;
      end
   end

   // address counters wrap naturally at the memory size
   always_ff @(posedge clk) begin
      if (reset) begin
         w_addr <= '0;
         r_addr <= '0;
         level  <= '0;
      end else begin
         if (w_en_int) begin
            w_addr <= w_addr + W_ADDR_W'(1);
         end
         if (r_en_int) begin
            r_addr <= r_addr + R_ADDR_W'(1);
         end
         level <= level_nxt;
      end
   end

   // empty below one read unit, full when a write unit no longer fits
   assign r_empty = level < R_INCR;
   assign w_full  = level > FULL_MARK;

   ram_2p_asym #(
      .W_DATA_W (W_DATA_W),
      .R_DATA_W (R_DATA_W),
      .ADDR_W   (ADDR_W)
   ) ram (
      .clk    (clk),
      .w_en   (w_en_int),
      .w_data (w_data),
      .w_addr (w_addr),
      .r_en   (r_en_int),
      .r_addr (r_addr),
      .r_data (r_data)
   );

endmodule

// File: verilog/ram_2p_asym.sv
`timescale 1ns/100ps
`include "fifo_util.svh"

module ram_2p_asym #(
   parameter W_DATA_W  = 8,
   parameter R_DATA_W  = 32,
   parameter ADDR_W    = 4,
   parameter MAXDATA_W = `FIFO_MAX(W_DATA_W, R_DATA_W),
   parameter MINDATA_W = `FIFO_MIN(W_DATA_W, R_DATA_W),
   parameter N         = MAXDATA_W / MINDATA_W,
   parameter MINADDR_W = ADDR_W - $clog2(N),
   parameter W_ADDR_W  = (W_DATA_W == MAXDATA_W) ? MINADDR_W : ADDR_W,
   parameter R_ADDR_W  = (R_DATA_W == MAXDATA_W) ? MINADDR_W : ADDR_W
) (
   input  logic                clk,
   input  logic                w_en,
   input  logic [W_DATA_W-1:0] w_data,
   input  logic [W_ADDR_W-1:0] w_addr,
   input  logic                r_en,
   input  logic [R_ADDR_W-1:0] r_addr,
   output logic [R_DATA_W-1:0] r_data
);

   localparam int SEL_W = $clog2(N);
   localparam int DEPTH = 2 ** MINADDR_W;

   logic [MINADDR_W-1:0]        w_row;
   logic [MINADDR_W-1:0]        r_row;
   logic [N-1:0]                bank_we;
   logic [N-1:0][MINDATA_W-1:0] bank_wdata;
   logic [N-1:0][MINDATA_W-1:0] bank_rd;

   // write side: a wide word covers every bank of one row
   if (W_DATA_W == MAXDATA_W) begin : g_wr_wide
      assign w_row      = w_addr;
      assign bank_we    = {N{w_en}};
      assign bank_wdata = w_data;
   end else begin : g_wr_narrow
      logic [SEL_W-1:0] w_sel;

      // low address bits pick the bank, lowest address is the lsb part
      assign w_sel      = w_addr[SEL_W-1:0];
      assign w_row      = w_addr[ADDR_W-1:SEL_W];
      assign bank_wdata = {N{w_data}};
      for (genvar b = 0; b < N; b++) begin : g_we
         assign bank_we[b] = w_en && (w_sel == SEL_W'(b));
      end
   end

   for (genvar b = 0; b < N; b++) begin : g_bank
      logic [MINDATA_W-1:0] mem [DEPTH];
      logic [MINDATA_W-1:0] q;

      always_ff @(posedge clk) begin
         if (bank_we[b]) begin
            mem[w_row] <= bank_wdata[b];
         end
         if (r_en) begin
            q <= mem[r_row];
         end
      end

      assign bank_rd[b] = q;
   end

   // read side: registered row, bank select follows the same register
   if (R_DATA_W == MAXDATA_W) begin : g_rd_wide
      assign r_row  = r_addr;
      assign r_data = bank_rd;
   end else begin : g_rd_narrow
      logic [SEL_W-1:0] r_sel_q;

      assign r_row = r_addr[ADDR_W-1:SEL_W];

      always_ff @(posedge clk) begin
         if (r_en) begin
            r_sel_q <= r_addr[SEL_W-1:0];
         end
      end

      assign r_data = bank_rd[r_sel_q];
   end

endmodule

// File: verilog/result_stage.sv
`timescale 1ns/100ps

module result_stage (
   input  logic                       clk,
   input  logic                       reset,
   input  cmd_pkg::res_t              res,
   output logic                       res_busy,
   output logic                       fifo_wr,
   output logic [cmd_pkg::word_w-1:0] fifo_wdata,
   input  logic                       fifo_full
);

   import cmd_pkg::*;

   logic              hold_valid;
   logic [word_w-1:0] hold_data;
   logic              accept;

   // drain whenever the fifo has room for a whole word
   assign fifo_wr    = hold_valid && !fifo_full;
   assign fifo_wdata = hold_data;

   // a draining slot can take a new word in the same cycle
   assign res_busy = hold_valid && fifo_full;
   assign accept   = res.valid && !res_busy;

   always_ff @(posedge clk) begin
      if (reset) begin
         hold_valid <= 1'b0;
      end else begin
         hold_valid <= accept || (hold_valid && !fifo_wr);
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         hold_data <= res.data;
      end
   end

endmodule
